// ==== design/rom_check_pkg.sv ====
// ROM check shared definitions
`default_nettype none

package rom_check_pkg;

  // Four-bit boolean with a single valid true and a single valid false encoding
  typedef logic [3:0] mubi4_t;

  parameter mubi4_t MuBi4True  = 4'h6;
  parameter mubi4_t MuBi4False = 4'h9;

  // Checker FSM states are ten bits wide
  // Only Done carries MuBi4True in its low nibble, so the nibble doubles as the done flag
  // The reset state carries MuBi4False there
  typedef enum logic [9:0] {
    ReadingLow  = 10'b0001011001,
    ReadingHigh = 10'b0110100101,
    RomAhead    = 10'b1100011001,
    KmacAhead   = 10'b1000101100,
    Checking    = 10'b0111011010,
    Done        = 10'b0010110110,
    Invalid     = 10'b1101000000
  } fsm_state_e;

  // Number of bits needed to index a memory of the given depth and never below one
  function automatic int addr_bits(input int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

endpackage

`default_nettype wire

// ==== design/rom_scan_if.sv ====
// ROM scan interface
`timescale 1ns/1ns
`default_nettype none

interface rom_scan_if #(
  parameter int AddrW = 5
);

  // Read side, one ROM read per cycle while read_req is high
  logic [AddrW-1:0] read_addr;
  logic             read_req;

  // Data side, names the word that is on the ROM data bus this cycle
  logic [AddrW-1:0] data_addr;
  logic             data_rdy;
  logic             data_last_nontop;
  logic             done;

  modport counter (
    output read_addr, read_req, data_addr, data_last_nontop, done,
    input  data_rdy
  );

  modport fsm (
    input  read_addr, read_req, data_addr, data_last_nontop, done,
    output data_rdy
  );

endinterface

`default_nettype wire

// ==== design/rom_addr_counter.sv ====
// ROM address counter
`timescale 1ns/1ns
`default_nettype none

module rom_addr_counter #(
  parameter int RomDepth = 32,
  parameter int TopCount = 8
) (
  input wire logic   clk_i,
  input wire logic   rst_ni,
  rom_scan_if.counter scan_o
);

  import rom_check_pkg::*;

  localparam int Aw = addr_bits(RomDepth);
  localparam logic [Aw-1:0] LastAddr    = Aw'(RomDepth - 1);
  localparam logic [Aw-1:0] LastLowAddr = Aw'(RomDepth - TopCount - 1);

  logic [Aw-1:0] read_addr_q, data_addr_q;
  logic          pending_q, all_read_q, done_q;
  logic          consume, read_req;

  // A word is pending between its read and the cycle the FSM takes it
  assign consume  = pending_q & scan_o.data_rdy;

  // Keep at most one word ahead of the consumer
  assign read_req = ~all_read_q & (~pending_q | consume);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
      data_addr_q <= '0;
      pending_q   <= 1'b0;
      all_read_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      pending_q <= read_req | (pending_q & ~scan_o.data_rdy);
      if (read_req) begin
        // The top address is read last and then the flag marks reads as finished
        if (read_addr_q == LastAddr) all_read_q <= 1'b1;
        else read_addr_q <= read_addr_q + 1'b1;
      end
      if (consume) begin
        if (data_addr_q == LastAddr) done_q <= 1'b1;
        else data_addr_q <= data_addr_q + 1'b1;
      end
    end
  end

  assign scan_o.read_addr        = read_addr_q;
  assign scan_o.read_req         = read_req;
  assign scan_o.data_addr        = data_addr_q;
  assign scan_o.data_last_nontop = (data_addr_q == LastLowAddr);
  assign scan_o.done             = done_q;

  // While a word is pending the read address runs exactly one word ahead of it
  ReadOneAhead_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q && !all_read_q |-> read_addr_q == data_addr_q + 1'b1);

endmodule

`default_nettype wire

// ==== design/digest_regs.sv ====
// Digest register block
`timescale 1ns/1ns
`default_nettype none

module digest_regs #(
  parameter int TopCount = 8
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  input  wire logic                                       digest_vld_i,
  input  wire logic [TopCount*32-1:0]                     digest_i,
  input  wire logic                                       exp_vld_i,
  input  wire logic [rom_check_pkg::addr_bits(TopCount)-1:0] exp_idx_i,
  input  wire logic [31:0]                                exp_word_i,
  output logic      [TopCount*32-1:0]                     digest_o,
  output logic      [TopCount*32-1:0]                     exp_digest_o
);

  logic [TopCount*32-1:0] digest_q, exp_q;

  // Computed digest arrives all at once from the hash engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (digest_vld_i) begin
      digest_q <= digest_i;
    end
  end

  // Expected digest is filled one word at a time as the top of ROM is read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_q <= '0;
    end else if (exp_vld_i) begin
      exp_q[exp_idx_i*32 +: 32] <= exp_word_i;
    end
  end

  assign digest_o     = digest_q;
  assign exp_digest_o = exp_q;

  // The FSM must only snoop addresses that belong to the digest
  ExpIdxInRange_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_vld_i |-> (int'(exp_idx_i) < TopCount));

endmodule

`default_nettype wire

// ==== design/digest_compare.sv ====
// Digest comparator
`timescale 1ns/1ns
`default_nettype none

module digest_compare #(
  parameter int TopCount = 8
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire logic [TopCount*32-1:0] digest_i,
  input  wire logic [TopCount*32-1:0] exp_digest_i,
  output logic                        done_o,
  output rom_check_pkg::mubi4_t       good_o,
  output logic                        alert_o
);

  import rom_check_pkg::*;

  localparam int Iw = addr_bits(TopCount);
  localparam logic [Iw-1:0] LastIdx = Iw'(TopCount - 1);

  logic [Iw-1:0] idx_q;
  logic          busy_q, match_q, done_q, alert_q;
  mubi4_t        good_q;
  logic          word_eq, all_eq;

  // Compare the word selected by the running index
  assign word_eq = (digest_i[idx_q*32 +: 32] == exp_digest_i[idx_q*32 +: 32]);
  assign all_eq  = match_q & word_eq;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q   <= '0;
      busy_q  <= 1'b0;
      match_q <= 1'b0;
      done_q  <= 1'b0;
      alert_q <= 1'b0;
      good_q  <= MuBi4False;
    end else begin
      // Done and alert are single-cycle pulses
      done_q  <= 1'b0;
      alert_q <= 1'b0;
      if (start_i) begin
        idx_q   <= '0;
        busy_q  <= 1'b1;
        match_q <= 1'b1;
        good_q  <= MuBi4False;
      end else if (busy_q) begin
        match_q <= all_eq;
        if (idx_q == LastIdx) begin
          busy_q  <= 1'b0;
          done_q  <= 1'b1;
          alert_q <= ~all_eq;
          good_q  <= all_eq ? MuBi4True : MuBi4False;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  assign done_o  = done_q;
  assign good_o  = good_q;
  assign alert_o = alert_q;

  // The FSM starts one comparison only and never restarts it midway
  NoStartWhileBusy_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== design/rom_check_fsm.sv ====
// ROM checker FSM
`timescale 1ns/1ns
`default_nettype none

module rom_check_fsm #(
  parameter int RomDepth = 32,
  parameter int TopCount = 8
) (
  input  wire logic                                           clk_i,
  input  wire logic                                           rst_ni,
  rom_scan_if.fsm                                             scan_i,
  input  wire logic                                           kmac_rom_rdy_i,
  output logic                                                kmac_rom_vld_o,
  output logic                                                kmac_rom_last_o,
  input  wire logic                                           kmac_done_i,
  input  wire logic                                           kmac_err_i,
  output logic                                                cmp_start_o,
  input  wire logic                                           cmp_done_i,
  input  wire rom_check_pkg::mubi4_t                          cmp_good_i,
  input  wire logic                                           cmp_alert_i,
  output logic                                                exp_vld_o,
  output logic      [rom_check_pkg::addr_bits(TopCount)-1:0] exp_idx_o,
  output rom_check_pkg::mubi4_t                               done_o,
  output rom_check_pkg::mubi4_t                               good_o,
  output logic                                                keymgr_valid_o,
  output logic                                                alert_o
);

  import rom_check_pkg::*;

  localparam int Aw = addr_bits(RomDepth);
  localparam int Tw = addr_bits(TopCount);
  localparam logic [Aw-1:0] TopStartAddr = Aw'(RomDepth - TopCount);

  fsm_state_e state_d, state_q;
  logic [9:0] state_bits;
  logic       fsm_alert, unexpected_drop;
  logic       vld_d, vld_q, start_q;
  logic [Aw-1:0] rel_addr;

  // The sequence is linear apart from the race between the hash result and the top reads
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      ReadingLow: begin
        // Leave once the last low word has been accepted by the hash engine
        if (scan_i.data_last_nontop && kmac_rom_rdy_i && vld_q) state_d = ReadingHigh;
      end
      ReadingHigh: begin
        unique case ({kmac_done_i, scan_i.done})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = kmac_err_i ? Invalid : KmacAhead;
          2'b11:   state_d = kmac_err_i ? Invalid : Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (kmac_done_i) state_d = kmac_err_i ? Invalid : Checking;
      end
      KmacAhead: begin
        if (scan_i.done) state_d = Checking;
      end
      Checking: begin
        if (cmp_done_i) state_d = Done;
      end
      Done: begin
        state_d = Done;
      end
      Invalid: begin
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
      default: begin
        // Any encoding outside the list is treated like Invalid
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
    endcase

    // Done signals that show up in the wrong state mean the sequence was broken
    if ((cmp_done_i && !(state_q inside {Checking, Done})) ||
        (scan_i.done && state_q == ReadingLow) ||
        (kmac_done_i && !(state_q inside {ReadingHigh, RomAhead}))) begin
      state_d = Invalid;
    end

    // Other alert sources also lock the FSM up
    if (cmp_alert_i || unexpected_drop) state_d = Invalid;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // Low nibble of the state is the done flag and is true only in Done
  assign state_bits = state_q;
  assign done_o     = state_bits[3:0];
  assign good_o     = cmp_good_i;
  assign keymgr_valid_o = (done_o == MuBi4True);

  // Once finished the counter must hold done or it was disturbed
  assign unexpected_drop = (done_o == MuBi4True) & ~scan_i.done;

  assign alert_o = fsm_alert | cmp_alert_i | unexpected_drop;

  // Hash valid is set for each low-part read and cleared once the word is taken
  always_comb begin
    vld_d = vld_q;
    if (kmac_rom_rdy_i) vld_d = 1'b0;
    if (scan_i.read_req && state_q == ReadingLow && !scan_i.data_last_nontop) vld_d = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      vld_q   <= vld_d;
      // One pulse on entry to Checking
      start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  assign kmac_rom_vld_o  = vld_q;
  assign kmac_rom_last_o = scan_i.data_last_nontop;
  assign cmp_start_o     = start_q;

  // Top words are not hashed, so they are drained without waiting for the engine
  assign scan_i.data_rdy = kmac_rom_rdy_i | (state_q inside {ReadingHigh, KmacAhead});

  // Snoop the top part of ROM into the expected digest
  assign rel_addr  = scan_i.data_addr - TopStartAddr;
  assign exp_vld_o = (state_q inside {ReadingHigh, KmacAhead}) & ~scan_i.done;
  assign exp_idx_o = rel_addr[Tw-1:0];

  LastImpliesValid_A: assert property (@(posedge clk_i)
    disable iff (!rst_ni || state_q == Invalid)
    kmac_rom_last_o |-> kmac_rom_vld_o);

  // The counter must see the top words drained while the digest is captured
  // Each such cycle moves the data address on by one word until done
  TopDrained_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q inside {ReadingHigh, KmacAhead}) && !scan_i.done |=>
    scan_i.done || (scan_i.data_addr == $past(scan_i.data_addr) + 1'b1));

endmodule

`default_nettype wire

// ==== design/rom_access_arb.sv ====
// ROM port arbiter
`timescale 1ns/1ns
`default_nettype none

module rom_access_arb #(
  parameter int RomDepth = 32
) (
  input  wire logic                                           clk_i,
  input  wire logic                                           rst_ni,
  input  wire rom_check_pkg::mubi4_t                          checker_done_i,
  input  wire logic      [rom_check_pkg::addr_bits(RomDepth)-1:0] chk_addr_i,
  input  wire logic                                           chk_req_i,
  input  wire logic                                           bus_req_i,
  input  wire logic      [rom_check_pkg::addr_bits(RomDepth)-1:0] bus_addr_i,
  output logic           [rom_check_pkg::addr_bits(RomDepth)-1:0] rom_addr_o,
  output logic                                                rom_req_o,
  input  wire logic      [31:0]                               rom_data_i,
  output logic                                                bus_rvalid_o,
  output logic           [31:0]                               bus_rdata_o
);

  import rom_check_pkg::*;

  logic bus_sel;
  logic rvalid_q;

  // Strict test, any encoding other than true keeps the checker in charge
  assign bus_sel = (checker_done_i == MuBi4True);

  assign rom_addr_o = bus_sel ? bus_addr_i : chk_addr_i;
  assign rom_req_o  = bus_sel ? bus_req_i : chk_req_i;

  // ROM answers one cycle after an accepted bus read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_sel & bus_req_i;
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rvalid_q ? rom_data_i : '0;

  // Ownership passes to the bus once and never comes back
  BusOwnerSticky_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_sel |=> bus_sel);

endmodule

`default_nettype wire

// ==== design/rom_check_top.sv ====
// ROM integrity checker top
`timescale 1ns/1ns
`default_nettype none

module rom_check_top #(
  parameter int RomDepth = 32,
  parameter int TopCount = 8
) (
  input  wire logic                                           clk_i,
  input  wire logic                                           rst_ni,
  output logic      [rom_check_pkg::addr_bits(RomDepth)-1:0] rom_addr_o,
  output logic                                                rom_req_o,
  input  wire logic [31:0]                                    rom_data_i,
  input  wire logic                                           kmac_rom_rdy_i,
  output logic                                                kmac_rom_vld_o,
  output logic                                                kmac_rom_last_o,
  input  wire logic                                           kmac_done_i,
  input  wire logic [TopCount*32-1:0]                         kmac_digest_i,
  input  wire logic                                           kmac_err_i,
  input  wire logic                                           bus_req_i,
  input  wire logic [rom_check_pkg::addr_bits(RomDepth)-1:0] bus_addr_i,
  output logic                                                bus_rvalid_o,
  output logic      [31:0]                                    bus_rdata_o,
  output rom_check_pkg::mubi4_t                               done_o,
  output rom_check_pkg::mubi4_t                               good_o,
  output logic                                                keymgr_valid_o,
  output logic      [TopCount*32-1:0]                         keymgr_digest_o,
  output logic                                                alert_o
);

  import rom_check_pkg::*;

  localparam int Aw = addr_bits(RomDepth);
  localparam int Tw = addr_bits(TopCount);

  logic                   cmp_start, cmp_done, cmp_alert;
  mubi4_t                 cmp_good, fsm_done;
  logic                   exp_vld;
  logic [Tw-1:0]          exp_idx;
  logic [TopCount*32-1:0] digest, exp_digest;

  rom_scan_if #(.AddrW(Aw)) scan ();

  // Walks the whole ROM once after reset
  rom_addr_counter #(.RomDepth(RomDepth), .TopCount(TopCount)) u_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scan_o (scan.counter)
  );

  rom_check_fsm #(.RomDepth(RomDepth), .TopCount(TopCount)) u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scan_i          (scan.fsm),
    .kmac_rom_rdy_i  (kmac_rom_rdy_i),
    .kmac_rom_vld_o  (kmac_rom_vld_o),
    .kmac_rom_last_o (kmac_rom_last_o),
    .kmac_done_i     (kmac_done_i),
    .kmac_err_i      (kmac_err_i),
    .cmp_start_o     (cmp_start),
    .cmp_done_i      (cmp_done),
    .cmp_good_i      (cmp_good),
    .cmp_alert_i     (cmp_alert),
    .exp_vld_o       (exp_vld),
    .exp_idx_o       (exp_idx),
    .done_o          (fsm_done),
    .good_o          (good_o),
    .keymgr_valid_o  (keymgr_valid_o),
    .alert_o         (alert_o)
  );

  // Expected words come straight off the ROM data bus
  digest_regs #(.TopCount(TopCount)) u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .digest_vld_i (kmac_done_i),
    .digest_i     (kmac_digest_i),
    .exp_vld_i    (exp_vld),
    .exp_idx_i    (exp_idx),
    .exp_word_i   (rom_data_i),
    .digest_o     (digest),
    .exp_digest_o (exp_digest)
  );

  digest_compare #(.TopCount(TopCount)) u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (cmp_start),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .done_o       (cmp_done),
    .good_o       (cmp_good),
    .alert_o      (cmp_alert)
  );

  // The bus only gets the ROM once the check has finished
  rom_access_arb #(.RomDepth(RomDepth)) u_arb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .checker_done_i (fsm_done),
    .chk_addr_i     (scan.read_addr),
    .chk_req_i      (scan.read_req),
    .bus_req_i      (bus_req_i),
    .bus_addr_i     (bus_addr_i),
    .rom_addr_o     (rom_addr_o),
    .rom_req_o      (rom_req_o),
    .rom_data_i     (rom_data_i),
    .bus_rvalid_o   (bus_rvalid_o),
    .bus_rdata_o    (bus_rdata_o)
  );

  assign done_o          = fsm_done;
  assign keymgr_digest_o = digest;

endmodule

`default_nettype wire

// ==== verif/tb_rom_check.sv ====
// ROM checker testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rom_check;

  import rom_check_pkg::*;

  localparam int RomDepth = 32;
  localparam int TopCount = 8;
  localparam int AddrW    = addr_bits(RomDepth);
  localparam int LowCount = RomDepth - TopCount;
  localparam int DigestW  = TopCount * 32;
  localparam int NumRows  = 5;
  localparam int TimeoutCycles = 2000;
  localparam logic [31:0] Seed = 32'h5a0ef9c1;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic [AddrW-1:0]   rom_addr_o, bus_addr_i;
  logic               rom_req_o, bus_req_i, bus_rvalid_o;
  logic [31:0]        rom_data_i, bus_rdata_o;
  logic               kmac_rom_rdy_i, kmac_rom_vld_o, kmac_rom_last_o;
  logic               kmac_done_i, kmac_err_i, keymgr_valid_o, alert_o;
  logic [DigestW-1:0] kmac_digest_i, keymgr_digest_o;
  mubi4_t             done_o, good_o;

  // Test table with one entry per row
  string  row_name [NumRows];
  int     row_stall [NumRows];
  int     row_delay [NumRows];
  bit     row_corrupt [NumRows];
  bit     row_err [NumRows];
  mubi4_t row_good [NumRows];
  bit     row_alert [NumRows];

  // ROM contents and model state
  logic [31:0]        mem [RomDepth];
  logic [31:0]        rom_lfsr, rdy_lfsr;
  logic [DigestW-1:0] ref_digest, acc_digest;
  string              cur_name;
  int                 cur_stall, cur_delay;
  bit                 cur_err, done_seen, keymgr_seen;
  int                 acc_cnt, hash_wait, cyc, alert_cyc, kdone_cyc;
  int                 errors = 0;

  rom_check_top #(.RomDepth(RomDepth), .TopCount(TopCount)) UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rom_addr_o      (rom_addr_o),
    .rom_req_o       (rom_req_o),
    .rom_data_i      (rom_data_i),
    .kmac_rom_rdy_i  (kmac_rom_rdy_i),
    .kmac_rom_vld_o  (kmac_rom_vld_o),
    .kmac_rom_last_o (kmac_rom_last_o),
    .kmac_done_i     (kmac_done_i),
    .kmac_digest_i   (kmac_digest_i),
    .kmac_err_i      (kmac_err_i),
    .bus_req_i       (bus_req_i),
    .bus_addr_i      (bus_addr_i),
    .bus_rvalid_o    (bus_rvalid_o),
    .bus_rdata_o     (bus_rdata_o),
    .done_o          (done_o),
    .good_o          (good_o),
    .keymgr_valid_o  (keymgr_valid_o),
    .keymgr_digest_o (keymgr_digest_o),
    .alert_o         (alert_o)
  );

  always #20 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Digest word k of the hash model collects every stream word rotated left by k
  function automatic logic [DigestW-1:0] fold_word(input logic [DigestW-1:0] d,
                                                    input logic [31:0] w);
    logic [63:0] dbl;
    for (int k = 0; k < TopCount; k++) begin
      dbl = {w, w} << k;
      d[k*32 +: 32] = d[k*32 +: 32] ^ dbl[63:32];
    end
    return d;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rom_lfsr = lfsr_next(rom_lfsr);
      v = {v[30:0], rom_lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string what, input logic [255:0] exp,
                                 input logic [255:0] act);
    errors++;
    $display("FAILED %s %s expected %0h actual %0h", cur_name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error in %s: %s", cur_name, msg);
  endtask

  task automatic set_row(input int r, input string name, input int stall, input int delay,
                         input bit corrupt, input bit err, input mubi4_t good,
                         input bit alert);
    row_name[r]    = name;
    row_stall[r]   = stall;
    row_delay[r]   = delay;
    row_corrupt[r] = corrupt;
    row_err[r]     = err;
    row_good[r]    = good;
    row_alert[r]   = alert;
  endtask

  // Fills the ROM and clears the models while the DUT sits in reset
  task automatic start_row(input int r);
    logic [31:0]        w;
    logic [DigestW-1:0] d;
    cur_name  = row_name[r];
    cur_stall = row_stall[r];
    cur_delay = row_delay[r];
    cur_err   = row_err[r];
    rom_lfsr  = Seed + 32'(r) * 32'h0000_9e37;
    d = '0;
    for (int i = 0; i < LowCount; i++) begin
      take_bits(32, w);
      mem[i] = w;
      d = fold_word(d, w);
    end
    // Top of ROM holds the expected digest
    for (int k = 0; k < TopCount; k++) begin
      mem[LowCount+k] = d[k*32 +: 32];
    end
    if (row_corrupt[r]) mem[LowCount+3] = mem[LowCount+3] ^ 32'h0001_0000;
    ref_digest  = d;
    rdy_lfsr    = rom_lfsr;
    acc_digest  = '0;
    acc_cnt     = 0;
    hash_wait   = -1;
    cyc         = 0;
    alert_cyc   = -1;
    kdone_cyc   = -1;
    done_seen   = 1'b0;
    keymgr_seen = 1'b0;
    if (kmac_rom_vld_o !== 1'b0) report_mismatch("reset valid", 0, kmac_rom_vld_o);
    if (alert_o !== 1'b0) report_mismatch("reset alert", 0, alert_o);
    if (keymgr_valid_o !== 1'b0) report_mismatch("reset keymgr", 0, keymgr_valid_o);
    if (done_o !== MuBi4False) report_mismatch("reset done", MuBi4False, done_o);
    if (bus_rvalid_o !== 1'b0) report_mismatch("reset rvalid", 0, bus_rvalid_o);
  endtask

  task automatic wait_for_end();
    int n;
    n = 0;
    while (n < TimeoutCycles && done_o !== MuBi4True && alert_o !== 1'b1) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TimeoutCycles) report_problem("timeout, the checker reached neither done nor alert");
  endtask

  // A bus read returns its data one cycle after the request
  task automatic bus_read(input logic [AddrW-1:0] a);
    @(posedge clk_i);
    bus_req_i  <= 1'b1;
    bus_addr_i <= a;
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    @(negedge clk_i);
    if (bus_rvalid_o !== 1'b1) report_mismatch("bus rvalid", 1, bus_rvalid_o);
    if (bus_rdata_o !== mem[a]) report_mismatch("bus rdata", mem[a], bus_rdata_o);
  endtask

  // ROM storage with one cycle of read latency
  always @(posedge clk_i) begin
    if (rom_req_o) rom_data_i <= mem[rom_addr_o];
  end

  // Ready is either held high or taken bit by bit from its own LFSR
  always @(posedge clk_i) begin
    if (!rst_ni || cur_stall == 0) begin
      kmac_rom_rdy_i <= 1'b1;
    end else begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      kmac_rom_rdy_i <= rdy_lfsr[0];
    end
  end

  // The hash result is pulsed once the row's delay after the last word has run out
  always @(posedge clk_i) begin
    kmac_done_i <= 1'b0;
    if (rst_ni) begin
      if (hash_wait == 0) begin
        kmac_done_i   <= 1'b1;
        kmac_digest_i <= acc_digest;
        kmac_err_i    <= cur_err;
      end
      if (hash_wait >= 0) hash_wait = hash_wait - 1;
    end
  end

  // The stream and status monitor samples mid-cycle where everything is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      cyc++;
      if (kmac_rom_last_o && !kmac_rom_vld_o) report_problem("last flag seen without valid");
      if (kmac_rom_vld_o && kmac_rom_rdy_i) begin
        if (acc_cnt >= LowCount) begin
          report_problem("hash stream carried more words than the low part of ROM");
        end else begin
          if (rom_data_i !== mem[acc_cnt]) report_mismatch("stream word", mem[acc_cnt], rom_data_i);
          if (kmac_rom_last_o !== (acc_cnt == LowCount - 1))
            report_mismatch("stream last", acc_cnt == LowCount - 1, kmac_rom_last_o);
        end
        acc_digest = fold_word(acc_digest, rom_data_i);
        if (kmac_rom_last_o) hash_wait = cur_delay;
        acc_cnt++;
      end
      if (bus_rvalid_o && done_o !== MuBi4True) report_problem("bus read returned before done");
      if (alert_o && alert_cyc < 0) alert_cyc = cyc;
      if (kmac_done_i && kdone_cyc < 0) kdone_cyc = cyc;
      if (done_o === MuBi4True) done_seen = 1'b1;
      if (keymgr_valid_o) keymgr_seen = 1'b1;
    end
  end

  initial begin
    logic [31:0] a;
    rst_ni = 1'b0;
    rom_data_i = '0;
    kmac_rom_rdy_i = 1'b0;
    kmac_done_i = 1'b0;
    kmac_digest_i = '0;
    kmac_err_i = 1'b0;
    bus_req_i = 1'b0;
    bus_addr_i = '0;
    cur_stall = 0;
    hash_wait = -1;
    // Name, stall, hash delay, corrupt, error, good, alert
    set_row(0, "match_short", 0, 1, 0, 0, MuBi4True, 0);
    set_row(1, "match_long_stall", 1, 24, 0, 0, MuBi4True, 0);
    set_row(2, "match_short_stall", 1, 0, 0, 0, MuBi4True, 0);
    set_row(3, "mismatch", 1, 3, 1, 0, MuBi4False, 1);
    set_row(4, "hash_error", 0, 2, 0, 1, MuBi4False, 1);

    for (int r = 0; r < NumRows; r++) begin
      @(posedge clk_i);
      rst_ni     <= 1'b0;
      // Stray bus requests that the arbiter has to ignore until done
      bus_req_i  <= 1'b1;
      bus_addr_i <= AddrW'(5);
      @(negedge clk_i);
      start_row(r);
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      wait_for_end();
      // Failing rows get a longer window to catch a late done
      for (int n = 0; n < (row_alert[r] ? 50 : 4); n++) @(negedge clk_i);

      if (acc_cnt != LowCount) report_mismatch("stream count", LowCount, acc_cnt);
      if ((alert_cyc >= 0) != row_alert[r]) report_mismatch("alert", row_alert[r], alert_cyc >= 0);
      if (done_seen == row_alert[r]) report_mismatch("done reached", !row_alert[r], done_seen);
      if (keymgr_seen == row_alert[r]) report_mismatch("keymgr valid", !row_alert[r], keymgr_seen);
      if (good_o !== row_good[r]) report_mismatch("good", row_good[r], good_o);
      if (!row_alert[r] && keymgr_digest_o !== ref_digest)
        report_mismatch("keymgr digest", ref_digest, keymgr_digest_o);
      if (row_err[r] && !(kdone_cyc >= 0 && alert_cyc > kdone_cyc))
        report_problem("alert did not follow the hash done pulse");

      if (!row_alert[r]) begin
        @(posedge clk_i);
        bus_req_i <= 1'b0;
        for (int n = 0; n < 6; n++) begin
          take_bits(AddrW, a);
          bus_read(a[AddrW-1:0]);
        end
      end
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
design/rom_check_pkg.sv
design/rom_scan_if.sv
design/rom_addr_counter.sv
design/digest_regs.sv
design/digest_compare.sv
design/rom_check_fsm.sv
design/rom_access_arb.sv
design/rom_check_top.sv
verif/tb_rom_check.sv

// ==== Bender.yml ====
package:
  name: rom_check

sources:
  - files:
      - design/rom_check_pkg.sv
      - design/rom_scan_if.sv
      - design/rom_addr_counter.sv
      - design/digest_regs.sv
      - design/digest_compare.sv
      - design/rom_check_fsm.sv
      - design/rom_access_arb.sv
      - design/rom_check_top.sv
  - target: simulation
    files:
      - verif/tb_rom_check.sv
